//--- issue.f
+incdir+.
issue_pkg.sv
issue_ibuffer.sv
issue_scoreboard.sv
issue_operands.sv
issue_dispatch.sv
issue_stage.sv
issue_properties.sv
issue_tb.sv

//--- issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Sizing of the issue stage, shared by the package and the RTL

// Number of warps scheduled by the core
`define ISSUE_NUM_WARPS 4

// Thread lanes per warp
`define ISSUE_NUM_THREADS 4

// Architectural registers per warp
`define ISSUE_NUM_REGS 32

// Data width of one lane
`define ISSUE_XLEN 32

// Entries in each per-warp instruction FIFO, kept a power of two
`define ISSUE_IBUF_DEPTH 4

// Width of the stall counters
`define ISSUE_PERF_BITS 16

// Tag width carried with each instruction
`define ISSUE_UUID_BITS 8

// Opcode width inside an execution unit
`define ISSUE_OP_BITS 4

`endif

//--- issue_dispatch.sv
`timescale 1ns/1ps

module issue_dispatch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 opd_valid,
    input  issue_pkg::operands_t opd_data,
    output logic                 opd_ready,
    output logic                 alu_valid,
    output issue_pkg::operands_t alu_data,
    input  logic                 alu_ready,
    output logic                 lsu_valid,
    output issue_pkg::operands_t lsu_data,
    input  logic                 lsu_ready,
    output logic                 sfu_valid,
    output issue_pkg::operands_t sfu_data,
    input  logic                 sfu_ready,
    output logic                 dispatch_stall
);
    localparam int NUM_UNITS = 3;

    // Unit slots follow the ex_type encoding: ALU, LSU, SFU
    logic [NUM_UNITS-1:0] unit_valid;
    logic [NUM_UNITS-1:0] unit_ready;
    logic [NUM_UNITS-1:0] unit_sel;
    issue_pkg::operands_t unit_data [NUM_UNITS];

    assign unit_ready = {sfu_ready, lsu_ready, alu_ready};

    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            unit_sel[u] = (opd_data.inst.ex_type == issue_pkg::ex_type_e'(u));
        end
    end

    // Only the target slot matters, so a stalled unit does not block the others
    assign opd_ready      = |(unit_sel & (~unit_valid | unit_ready));
    assign dispatch_stall = opd_valid && !opd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            unit_valid <= '0;
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (opd_valid && opd_ready && unit_sel[u]) begin
                    unit_valid[u] <= 1'b1;
                end else if (unit_ready[u]) begin
                    unit_valid[u] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (opd_valid && opd_ready && unit_sel[u]) begin
                unit_data[u] <= opd_data;
            end
        end
    end

    assign alu_valid = unit_valid[0];
    assign alu_data  = unit_data[0];
    assign lsu_valid = unit_valid[1];
    assign lsu_data  = unit_data[1];
    assign sfu_valid = unit_valid[2];
    assign sfu_data  = unit_data[2];

endmodule

//--- issue_ibuffer.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_ibuffer (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      decode_valid,
    input  issue_pkg::decode_t                        decode_data,
    output logic                                      decode_ready,
    output logic [`ISSUE_NUM_WARPS-1:0]               head_valid,
    output issue_pkg::decode_t [`ISSUE_NUM_WARPS-1:0] head_data,
    input  logic [`ISSUE_NUM_WARPS-1:0]               head_pop
);
    localparam int PTR_W = $clog2(`ISSUE_IBUF_DEPTH);
    localparam int CNT_W = $clog2(`ISSUE_IBUF_DEPTH + 1);

    issue_pkg::decode_t mem [`ISSUE_NUM_WARPS][`ISSUE_IBUF_DEPTH];
    logic [PTR_W-1:0] rd_ptr [`ISSUE_NUM_WARPS];
    logic [PTR_W-1:0] wr_ptr [`ISSUE_NUM_WARPS];
    logic [CNT_W-1:0] count [`ISSUE_NUM_WARPS];
    logic [`ISSUE_NUM_WARPS-1:0] full;
    logic [`ISSUE_NUM_WARPS-1:0] push;
    logic [`ISSUE_NUM_WARPS-1:0] pop;

    always_comb begin
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            full[w]       = (count[w] == CNT_W'(`ISSUE_IBUF_DEPTH));
            head_valid[w] = (count[w] != '0);
            head_data[w]  = mem[w][rd_ptr[w]];
            push[w]       = decode_valid && decode_ready
                            && (decode_data.wid == issue_pkg::wid_t'(w));
            pop[w]        = head_pop[w] && head_valid[w];
        end
    end

    // One full warp blocks the decoder, since the next wid is not known in advance
    assign decode_ready = ~|full;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                rd_ptr[w] <= '0;
                wr_ptr[w] <= '0;
                count[w]  <= '0;
            end
        end else begin
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                if (push[w]) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (pop[w]) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                if (push[w] && !pop[w]) begin
                    count[w] <= count[w] + 1'b1;
                end else if (pop[w] && !push[w]) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            if (push[w]) begin
                mem[w][wr_ptr[w]] <= decode_data;
            end
        end
    end

endmodule

//--- issue_operands.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_operands (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sb_valid,
    input  issue_pkg::decode_t    sb_data,
    output logic                  sb_ready,
    input  logic                  wb_valid,
    input  issue_pkg::writeback_t wb_data,
    output logic                  opd_valid,
    output issue_pkg::operands_t  opd_data,
    input  logic                  opd_ready
);
    issue_pkg::word_t rf [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS][`ISSUE_NUM_THREADS];
    // Marks the lanes that hold a written value while the other lanes read as zero
    logic [`ISSUE_NUM_THREADS-1:0] written [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS];
    issue_pkg::word_t [`ISSUE_NUM_THREADS-1:0] rs1_lanes;
    issue_pkg::word_t [`ISSUE_NUM_THREADS-1:0] rs2_lanes;
    logic accept;

    // One lane of one source register, with a same-cycle writeback taking priority
    function automatic issue_pkg::word_t fetch_lane(
        input issue_pkg::wid_t     wid,
        input issue_pkg::reg_idx_t rs,
        input int                  lane
    );
        issue_pkg::word_t value;
        if (wb_valid && wb_data.wid == wid && wb_data.rd == rs && wb_data.tmask[lane]) begin
            value = wb_data.data[lane];
        end else if (written[wid][rs][lane]) begin
            value = rf[wid][rs][lane];
        end else begin
            value = '0;
        end
        return value;
    endfunction

    always_comb begin
        for (int l = 0; l < `ISSUE_NUM_THREADS; l++) begin
            rs1_lanes[l] = fetch_lane(sb_data.wid, sb_data.rs1, l);
            rs2_lanes[l] = fetch_lane(sb_data.wid, sb_data.rs2, l);
        end
    end

    assign sb_ready = !opd_valid || opd_ready;
    assign accept   = sb_valid && sb_ready;

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            for (int l = 0; l < `ISSUE_NUM_THREADS; l++) begin
                if (wb_data.tmask[l]) begin
                    rf[wb_data.wid][wb_data.rd][l] <= wb_data.data[l];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
                    written[w][r] <= '0;
                end
            end
        end else if (wb_valid) begin
            written[wb_data.wid][wb_data.rd] <= written[wb_data.wid][wb_data.rd]
                                                | wb_data.tmask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opd_valid <= 1'b0;
        end else if (accept) begin
            opd_valid <= 1'b1;
        end else if (opd_ready) begin
            opd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opd_data.inst     <= sb_data;
            opd_data.rs1_data <= rs1_lanes;
            opd_data.rs2_data <= rs2_lanes;
        end
    end

endmodule

//--- issue_pkg.sv
`include "issue_defines.svh"

package issue_pkg;

    // Width types
    typedef logic [$clog2(`ISSUE_NUM_WARPS)-1:0] wid_t;
    typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [`ISSUE_XLEN-1:0]              word_t;
    typedef logic [`ISSUE_NUM_THREADS-1:0]       tmask_t;
    typedef logic [`ISSUE_UUID_BITS-1:0]         uuid_t;
    typedef logic [`ISSUE_PERF_BITS-1:0]         perf_cnt_t;

    // Target execution unit of an instruction
    typedef enum logic [1:0] {
        ex_alu,
        ex_lsu,
        ex_sfu
    } ex_type_e;

    // Scoreboard keeps its pick while the operand stage is stalled
    typedef enum logic {
        sel_idle,
        sel_hold
    } sel_state_e;

    // Decoded instruction as it leaves the decoder
    typedef struct packed {
        uuid_t                   uuid;
        wid_t                    wid;
        tmask_t                  tmask;
        ex_type_e                ex_type;
        logic [`ISSUE_OP_BITS-1:0] op;
        logic                    wb;
        reg_idx_t                rd;
        reg_idx_t                rs1;
        reg_idx_t                rs2;
        word_t                   imm;
    } decode_t;

    // Result returning from an execution unit
    typedef struct packed {
        wid_t                                wid;
        reg_idx_t                            rd;
        tmask_t                              tmask;
        word_t [`ISSUE_NUM_THREADS-1:0]      data;
    } writeback_t;

    // Instruction together with its source operands for every lane
    typedef struct packed {
        decode_t                             inst;
        word_t [`ISSUE_NUM_THREADS-1:0]      rs1_data;
        word_t [`ISSUE_NUM_THREADS-1:0]      rs2_data;
    } operands_t;

endpackage

//--- issue_properties.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_properties (
    input logic                       clk,
    input logic                       reset,
    input logic                       wb_valid,
    input issue_pkg::writeback_t      wb_data,
    input logic                       sb_valid,
    input logic                       sb_ready,
    input issue_pkg::operands_t       opd_data,
    input logic [2:0]                 unit_valid,
    input logic [2:0]                 unit_ready,
    input issue_pkg::operands_t [2:0] unit_data
);
    // Register file and pending bits rebuilt from writebacks and unit arrivals
    issue_pkg::word_t shadow_rf [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS][`ISSUE_NUM_THREADS];
    logic [`ISSUE_NUM_REGS-1:0] shadow_pend [`ISSUE_NUM_WARPS];
    issue_pkg::word_t [`ISSUE_NUM_THREADS-1:0] exp_rs1;
    issue_pkg::word_t [`ISSUE_NUM_THREADS-1:0] exp_rs2;
    logic [2:0] held;
    logic [2:0] arrive;
    logic [2:0] hazard;
    int unsigned fail_count = 0;

    // A unit register holds a new instruction unless it stalled on the last edge
    assign arrive = unit_valid & ~held;

    always_comb begin
        for (int l = 0; l < `ISSUE_NUM_THREADS; l++) begin
            exp_rs1[l] = shadow_rf[opd_data.inst.wid][opd_data.inst.rs1][l];
            exp_rs2[l] = shadow_rf[opd_data.inst.wid][opd_data.inst.rs2][l];
        end
        for (int u = 0; u < 3; u++) begin
            hazard[u] = shadow_pend[unit_data[u].inst.wid][unit_data[u].inst.rs1]
                        || shadow_pend[unit_data[u].inst.wid][unit_data[u].inst.rs2]
                        || (unit_data[u].inst.wb
                            && shadow_pend[unit_data[u].inst.wid][unit_data[u].inst.rd]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '0;
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                shadow_pend[w] <= '0;
                for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
                    for (int l = 0; l < `ISSUE_NUM_THREADS; l++) begin
                        shadow_rf[w][r][l] <= '0;
                    end
                end
            end
        end else begin
            held <= unit_valid & ~unit_ready;
            if (wb_valid) begin
                shadow_pend[wb_data.wid][wb_data.rd] <= 1'b0;
                for (int l = 0; l < `ISSUE_NUM_THREADS; l++) begin
                    if (wb_data.tmask[l]) begin
                        shadow_rf[wb_data.wid][wb_data.rd][l] <= wb_data.data[l];
                    end
                end
            end
            for (int u = 0; u < 3; u++) begin
                if (arrive[u] && unit_data[u].inst.wb) begin
                    shadow_pend[unit_data[u].inst.wid][unit_data[u].inst.rd] <= 1'b1;
                end
            end
        end
    end

    // Operands captured at the last edge include the writeback of that same edge
    assert property (@(posedge clk) disable iff (reset)
        $past(sb_valid && sb_ready)
        |-> opd_data.rs1_data == exp_rs1 && opd_data.rs2_data == exp_rs2)
        else begin
            fail_count++;
            $error("operand data differs from the shadow register file");
        end

    for (genvar u = 0; u < 3; u++) begin : g_unit
        assert property (@(posedge clk) disable iff (reset)
            unit_valid[u] |-> unit_data[u].inst.ex_type == issue_pkg::ex_type_e'(u))
            else begin
                fail_count++;
                $error("unit %0d holds an instruction of another type", u);
            end

        assert property (@(posedge clk) disable iff (reset)
            arrive[u] |-> !hazard[u])
            else begin
                fail_count++;
                $error("unit %0d received an instruction with a pending register", u);
            end

        assert property (@(posedge clk) disable iff (reset)
            unit_valid[u] && !unit_ready[u] |=> unit_valid[u] && $stable(unit_data[u]))
            else begin
                fail_count++;
                $error("unit %0d changed its output while stalled", u);
            end
    end

endmodule

bind issue_stage issue_properties props0 (
    .clk(clk),
    .reset(reset),
    .wb_valid(wb_valid),
    .wb_data(wb_data),
    .sb_valid(sb_valid),
    .sb_ready(sb_ready),
    .opd_data(opd_data),
    .unit_valid({sfu_valid, lsu_valid, alu_valid}),
    .unit_ready({sfu_ready, lsu_ready, alu_ready}),
    .unit_data({sfu_data, lsu_data, alu_data})
);

//--- issue_scoreboard.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_scoreboard (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [`ISSUE_NUM_WARPS-1:0]               head_valid,
    input  issue_pkg::decode_t [`ISSUE_NUM_WARPS-1:0] head_data,
    output logic [`ISSUE_NUM_WARPS-1:0]               head_pop,
    input  logic                                      wb_valid,
    input  issue_pkg::writeback_t                     wb_data,
    output logic                                      sb_valid,
    output issue_pkg::decode_t                        sb_data,
    input  logic                                      sb_ready
);
    logic [`ISSUE_NUM_REGS-1:0] pending [`ISSUE_NUM_WARPS];
    logic [`ISSUE_NUM_WARPS-1:0] eligible;
    logic rr_found;
    issue_pkg::wid_t rr_wid;
    issue_pkg::wid_t last_wid;
    issue_pkg::wid_t held_wid;
    issue_pkg::wid_t sel_wid;
    issue_pkg::sel_state_e state;
    logic fire;

    // A head may go only when none of its registers waits for a result
    always_comb begin
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            eligible[w] = head_valid[w]
                          && !pending[w][head_data[w].rs1]
                          && !pending[w][head_data[w].rs2]
                          && !(head_data[w].wb && pending[w][head_data[w].rd]);
        end
    end

    // Round-robin search that starts at the warp after the last pick
    always_comb begin
        issue_pkg::wid_t cand;
        rr_found = 1'b0;
        rr_wid   = last_wid;
        for (int i = 1; i <= `ISSUE_NUM_WARPS; i++) begin
            cand = issue_pkg::wid_t'(int'(last_wid) + i);
            if (!rr_found && eligible[cand]) begin
                rr_found = 1'b1;
                rr_wid   = cand;
            end
        end
    end

    // While held, the chosen head cannot turn ineligible, as only its own issue sets bits
    assign sel_wid  = (state == issue_pkg::sel_hold) ? held_wid : rr_wid;
    assign sb_valid = (state == issue_pkg::sel_hold) ? head_valid[held_wid] : rr_found;
    assign sb_data  = head_data[sel_wid];
    assign fire     = sb_valid && sb_ready;
    assign head_pop = fire ? (`ISSUE_NUM_WARPS'(1) << sel_wid) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= issue_pkg::sel_idle;
            last_wid <= '0;
            held_wid <= '0;
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                pending[w] <= '0;
            end
        end else begin
            if (wb_valid) begin
                pending[wb_data.wid][wb_data.rd] <= 1'b0;
            end
            // The issuing rd is never the one written back, so the order is harmless
            if (fire && sb_data.wb) begin
                pending[sel_wid][sb_data.rd] <= 1'b1;
            end
            if (fire) begin
                last_wid <= sel_wid;
                state    <= issue_pkg::sel_idle;
            end else if (sb_valid) begin
                held_wid <= sel_wid;
                state    <= issue_pkg::sel_hold;
            end
        end
    end

endmodule

//--- issue_stage.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  decode_valid,
    input  issue_pkg::decode_t    decode_data,
    output logic                  decode_ready,
    input  logic                  wb_valid,
    input  issue_pkg::writeback_t wb_data,
    output logic                  alu_valid,
    output issue_pkg::operands_t  alu_data,
    input  logic                  alu_ready,
    output logic                  lsu_valid,
    output issue_pkg::operands_t  lsu_data,
    input  logic                  lsu_ready,
    output logic                  sfu_valid,
    output issue_pkg::operands_t  sfu_data,
    input  logic                  sfu_ready,
    output issue_pkg::perf_cnt_t  ibuf_stalls,
    output issue_pkg::perf_cnt_t  scb_stalls
);
    logic [`ISSUE_NUM_WARPS-1:0]               head_valid;
    issue_pkg::decode_t [`ISSUE_NUM_WARPS-1:0] head_data;
    logic [`ISSUE_NUM_WARPS-1:0]               head_pop;
    logic                 sb_valid;
    issue_pkg::decode_t   sb_data;
    logic                 sb_ready;
    logic                 opd_valid;
    issue_pkg::operands_t opd_data;
    logic                 opd_ready;

    issue_ibuffer u_ibuffer (
        .clk(clk), .reset(reset),
        .decode_valid(decode_valid), .decode_data(decode_data), .decode_ready(decode_ready),
        .head_valid(head_valid), .head_data(head_data), .head_pop(head_pop)
    );

    issue_scoreboard u_scoreboard (
        .clk(clk), .reset(reset),
        .head_valid(head_valid), .head_data(head_data), .head_pop(head_pop),
        .wb_valid(wb_valid), .wb_data(wb_data),
        .sb_valid(sb_valid), .sb_data(sb_data), .sb_ready(sb_ready)
    );

    issue_operands u_operands (
        .clk(clk), .reset(reset),
        .sb_valid(sb_valid), .sb_data(sb_data), .sb_ready(sb_ready),
        .wb_valid(wb_valid), .wb_data(wb_data),
        .opd_valid(opd_valid), .opd_data(opd_data), .opd_ready(opd_ready)
    );

    issue_dispatch u_dispatch (
        .clk(clk), .reset(reset),
        .opd_valid(opd_valid), .opd_data(opd_data), .opd_ready(opd_ready),
        .alu_valid(alu_valid), .alu_data(alu_data), .alu_ready(alu_ready),
        .lsu_valid(lsu_valid), .lsu_data(lsu_data), .lsu_ready(lsu_ready),
        .sfu_valid(sfu_valid), .sfu_data(sfu_data), .sfu_ready(sfu_ready),
        .dispatch_stall()
    );

    // Lost cycles at the buffer and at the scoreboard
    always_ff @(posedge clk) begin
        if (reset) begin
            ibuf_stalls <= '0;
            scb_stalls  <= '0;
        end else begin
            if (decode_valid && !decode_ready) begin
                ibuf_stalls <= ibuf_stalls + 1'b1;
            end
            if (|head_valid && !sb_valid) begin
                scb_stalls <= scb_stalls + 1'b1;
            end
        end
    end

endmodule

//--- issue_tb.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_tb;
    localparam int NUM_INSTR  = 200;
    localparam int MAX_CYCLES = NUM_INSTR * 20;
    localparam int NUM_UNITS  = 3;

    logic clk = 1'b0;
    logic reset;
    logic decode_valid;
    issue_pkg::decode_t decode_data;
    logic decode_ready;
    logic wb_valid;
    issue_pkg::writeback_t wb_data;
    logic [NUM_UNITS-1:0] unit_valid;
    logic [NUM_UNITS-1:0] unit_ready;
    issue_pkg::operands_t unit_data [NUM_UNITS];
    issue_pkg::perf_cnt_t ibuf_stalls;
    issue_pkg::perf_cnt_t scb_stalls;

    int unsigned rng_state = 41;
    int cycle = 0;
    int sent = 0;
    int arrived = 0;
    int stall_count = 0;
    logic dec_fire = 1'b0;
    logic [NUM_UNITS-1:0] held = '0;
    issue_pkg::decode_t last_inst = '0;
    // Decoded uuids of each warp, oldest first
    issue_pkg::uuid_t warp_order [`ISSUE_NUM_WARPS][$];
    issue_pkg::writeback_t wb_queue [$];
    int wb_due [$];

    issue_stage dut0 (
        .clk(clk), .reset(reset),
        .decode_valid(decode_valid), .decode_data(decode_data), .decode_ready(decode_ready),
        .wb_valid(wb_valid), .wb_data(wb_data),
        .alu_valid(unit_valid[0]), .alu_data(unit_data[0]), .alu_ready(unit_ready[0]),
        .lsu_valid(unit_valid[1]), .lsu_data(unit_data[1]), .lsu_ready(unit_ready[1]),
        .sfu_valid(unit_valid[2]), .sfu_data(unit_data[2]), .sfu_ready(unit_ready[2]),
        .ibuf_stalls(ibuf_stalls), .scb_stalls(scb_stalls)
    );

    always #50 clk = ~clk;

    function automatic int unsigned rand_below(input int unsigned bound);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return (rng_state >> 16) % bound;
    endfunction

    function automatic issue_pkg::word_t rand_word();
        return {16'(rand_below(65536)), 16'(rand_below(65536))};
    endfunction

    // Few registers are used so that hazards come up often
    function automatic issue_pkg::decode_t make_inst(input int index);
        issue_pkg::decode_t inst;
        inst      = '0;
        inst.uuid = issue_pkg::uuid_t'(index);
        if (index > 0 && rand_below(4) == 0) begin
            // Reads the result of the instruction just before it
            inst.wid = last_inst.wid;
            inst.rs1 = last_inst.rd;
        end else begin
            inst.wid = issue_pkg::wid_t'(rand_below(`ISSUE_NUM_WARPS));
            inst.rs1 = issue_pkg::reg_idx_t'(rand_below(8));
        end
        inst.tmask   = issue_pkg::tmask_t'(rand_below(15) + 1);
        inst.ex_type = issue_pkg::ex_type_e'(rand_below(3));
        inst.op      = 4'(rand_below(16));
        inst.wb      = (rand_below(4) != 0);
        inst.rd      = issue_pkg::reg_idx_t'(rand_below(8));
        inst.rs2     = issue_pkg::reg_idx_t'(rand_below(8));
        inst.imm     = rand_word();
        return inst;
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic schedule_writeback(input issue_pkg::decode_t inst);
        issue_pkg::writeback_t wb;
        wb.wid   = inst.wid;
        wb.rd    = inst.rd;
        wb.tmask = inst.tmask;
        for (int l = 0; l < `ISSUE_NUM_THREADS; l++) begin
            wb.data[l] = rand_word();
        end
        wb_queue.push_back(wb);
        wb_due.push_back(cycle + 1 + int'(rand_below(8)));
    endtask

    // A due result may wait behind another one on the single writeback port
    task automatic drive_writeback();
        wb_valid = 1'b0;
        for (int i = 0; i < wb_due.size(); i++) begin
            if (!wb_valid && wb_due[i] <= cycle) begin
                wb_valid = 1'b1;
                wb_data  = wb_queue[i];
                wb_queue.delete(i);
                wb_due.delete(i);
            end
        end
    endtask

    task automatic check_arrival(input issue_pkg::decode_t inst);
        issue_pkg::uuid_t expected;
        assert (warp_order[inst.wid].size() > 0) begin
            expected = warp_order[inst.wid].pop_front();
            assert (inst.uuid == expected)
                else report_error($sformatf("warp %0d reached a unit with uuid %0d, expected %0d",
                                            inst.wid, inst.uuid, expected));
        end else begin
            abort_run($sformatf("An instruction of warp %0d was issued but never decoded",
                                inst.wid));
        end
    endtask

    // Runs on each falling edge where the outputs have settled and no input drives them
    task automatic run_cycle();
        cycle++;
        if (dec_fire) begin
            decode_valid = 1'b0;
        end
        if (!decode_valid && sent < NUM_INSTR && rand_below(4) != 0) begin
            decode_data  = make_inst(sent);
            last_inst    = decode_data;
            decode_valid = 1'b1;
            sent++;
        end
        drive_writeback();
        for (int u = 0; u < NUM_UNITS; u++) begin
            unit_ready[u] = (rand_below(4) != 0);
        end
        dec_fire = decode_valid && decode_ready;
        if (dec_fire) begin
            warp_order[decode_data.wid].push_back(decode_data.uuid);
        end
        if (decode_valid && !decode_ready) begin
            stall_count++;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (unit_valid[u] && !held[u]) begin
                check_arrival(unit_data[u].inst);
                arrived++;
            end
            if (unit_valid[u] && unit_ready[u] && unit_data[u].inst.wb) begin
                schedule_writeback(unit_data[u].inst);
            end
            held[u] = unit_valid[u] && !unit_ready[u];
        end
    endtask

    initial begin
        reset        = 1'b1;
        decode_valid = 1'b0;
        decode_data  = '0;
        wb_valid     = 1'b0;
        wb_data      = '0;
        unit_ready   = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        assert (decode_ready && unit_valid == '0 && ibuf_stalls == '0 && scb_stalls == '0)
            else report_error("outputs after reset differ from their reset values");
        while (arrived < NUM_INSTR) begin
            @(negedge clk);
            if (cycle >= MAX_CYCLES) begin
                abort_run("Timeout, not every instruction reached an execution unit");
            end else begin
                run_cycle();
                assert (dut0.props0.fail_count == 0)
                    else abort_run("A bound assertion on the issue stage failed");
            end
        end
        // Dependent pairs leave heads waiting, and one stall at most is counted per cycle
        assert (scb_stalls != '0 && int'(scb_stalls) <= cycle)
            else report_error($sformatf("scb_stalls is %0d, expected between 1 and %0d",
                                        scb_stalls, cycle));
        assert (ibuf_stalls == issue_pkg::perf_cnt_t'(stall_count)) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_error($sformatf("ibuf_stalls is %0d, expected %0d",
                                   ibuf_stalls, stall_count));
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the issue stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module issue_tb \
    -f issue.f -o issue_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/issue_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Test did not complete"; exit 1; }
echo "Test passed"
